//--- decodeStage.f
+incdir+sim
src/rvIsaPkg.sv
src/ctrlPkg.sv
src/controlUnit.sv
src/immGen.sv
src/decodeStage.sv
sim/decodeStageTb.sv

//--- Bender.yml
package:
  name: decodeStage

sources:
  - src/rvIsaPkg.sv
  - src/ctrlPkg.sv
  - src/controlUnit.sv
  - src/immGen.sv
  - src/decodeStage.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/decodeStageTb.sv

//--- sim/decodeRefModel.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// what the register stage should hold for one accepted word
typedef struct packed {
        ctrl_t        ctrl;
        logic [31:0]  imm;
        instrFields_t fields;
        logic         invalid;
} expect_t;

function automatic aluOp_e refAluOp(instrFields_t f, logic isReg);
        case (f.funct3)
                3'b000: return (isReg && f.funct7 == funct7Alt) ? aluSub : aluAdd;
                3'b001: return (f.funct7 == funct7Base) ? aluSll : aluNone;
                3'b010: return aluSlt;
                3'b011: return aluSltu;
                3'b100: return aluXor;
                3'b101: return (f.funct7 == funct7Base) ? aluSrl :
                               (f.funct7 == funct7Alt) ? aluSra : aluNone;
                3'b110: return aluOr;
                default: return aluAnd;
        endcase
endfunction

function automatic fpuOp_e refFpuOp(instrFields_t f);
        logic [2:0] f3;
        f3 = f.funct3;
        case (f.funct7)
                funct7FAdd: return fpuAdd;
                funct7FSub: return fpuSub;
                funct7FMul: return fpuMul;
                funct7FDiv: return fpuDiv;
                funct7FSqrt: return fpuSqrt;
                funct7FSgnj: return f3 == 3'd0 ? fpuSgnj : f3 == 3'd1 ? fpuSgnjn :
                                    f3 == 3'd2 ? fpuSgnjx : fpuNone;
                funct7FMinMax: return f3 == 3'd0 ? fpuMin : f3 == 3'd1 ? fpuMax : fpuNone;
                funct7FCmp: return f3 == 3'd2 ? fpuEq : f3 == 3'd1 ? fpuLt :
                                   f3 == 3'd0 ? fpuLe : fpuNone;
                funct7FMvXW: return f3 == 3'd0 ? fpuMvXW : f3 == 3'd1 ? fpuClass : fpuNone;
                funct7FCvtWS: return f.rs2 == 5'd0 ? fpuCvtW : f.rs2 == 5'd1 ? fpuCvtWu : fpuNone;
                funct7FCvtSW: return f.rs2 == 5'd0 ? fpuCvtSW :
                                     f.rs2 == 5'd1 ? fpuCvtSWu : fpuNone;
                funct7FMvWX: return fpuMvWX;
                default: return fpuNone;
        endcase
endfunction

function automatic logic [31:0] refImm(logic [31:0] w);
        case (w[6:0])
                opLoad, opImm, opJalr, opFlw: return {{20{w[31]}}, w[31:20]};
                opStore, opFsw: return {{20{w[31]}}, w[31:25], w[11:7]};
                opBranch: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                opLui, opAuipc: return {w[31:12], 12'h000};
                opJal: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                default: return 32'h0;
        endcase
endfunction

// one row of the integer table
function automatic ctrl_t rowCtrl(aluOp_e alu, logic src, logic rw, wbSrc_e wb);
        ctrl_t c;
        c = ctrlNop;
        c.aluOp = alu;
        c.aluSrc = src;
        c.regWrite = rw;
        c.wbSrc = wb;
        return c;
endfunction

function automatic expect_t refDecode(logic [31:0] w);
        instrFields_t f;
        ctrl_t        c;
        expect_t      e;
        logic         toInt;
        f = w;
        c = ctrlNop;
        e.invalid = 1'b0;
        case (f.opcode)
                opOp: c = rowCtrl(refAluOp(f, 1'b1), 1'b0, 1'b1, wbAlu);
                opImm: c = rowCtrl(refAluOp(f, 1'b0), 1'b1, 1'b1, wbAlu);
                opLoad: begin
                        c = rowCtrl(aluAdd, 1'b1, 1'b1, wbMem);
                        c.memRead = 1'b1;
                        c.memOp = f.funct3 == 3'b000 ? memLb : f.funct3 == 3'b001 ? memLh :
                                  f.funct3 == 3'b010 ? memLw : f.funct3 == 3'b100 ? memLbu :
                                  f.funct3 == 3'b101 ? memLhu : memNone;
                end
                opStore: begin
                        c = rowCtrl(aluAdd, 1'b1, 1'b0, wbPc);
                        c.memWrite = 1'b1;
                        c.memOp = f.funct3 == 3'b000 ? memSb : f.funct3 == 3'b001 ? memSh :
                                  f.funct3 == 3'b010 ? memSw : memNone;
                end
                opBranch: begin
                        c = rowCtrl(aluSub, 1'b0, 1'b0, wbPc);
                        c.branch = 1'b1;
                end
                opLui: c = rowCtrl(aluNone, 1'b0, 1'b1, wbImm);
                opAuipc: c = rowCtrl(aluAdd, 1'b1, 1'b1, wbAlu);
                opJal, opJalr: begin
                        c = (f.opcode == opJalr) ? rowCtrl(aluAdd, 1'b1, 1'b1, wbPc) :
                                                   rowCtrl(aluNone, 1'b0, 1'b1, wbPc);
                        c.jump = 1'b1;
                end
                opFlw: begin
                        c = rowCtrl(aluAdd, 1'b1, 1'b0, wbMem);
                        c.memRead = 1'b1;
                        c.memOp = memLw;
                        c.fpuOp = fpuLoad;
                        c.fpRegWrite = 1'b1;
                end
                opFsw: begin
                        c = rowCtrl(aluAdd, 1'b1, 1'b0, wbPc);
                        c.memWrite = 1'b1;
                        c.memOp = memSw;
                        c.memSrc = 1'b1; // store data from f regs
                        c.fpuOp = fpuStore;
                end
                opFmadd, opFmsub, opFnmsub, opFnmadd: begin
                        c.fpuOp = (f.opcode == opFmadd) ? fpuMadd :
                                  (f.opcode == opFmsub) ? fpuMsub :
                                  (f.opcode == opFnmsub) ? fpuNmsub : fpuNmadd;
                        c.fpuSrc = 1'b1;
                        c.fpRegWrite = 1'b1;
                end
                opFp: begin
                        c.fpuOp = refFpuOp(f);
                        toInt = c.fpuOp inside {fpuEq, fpuLt, fpuLe, fpuClass, fpuMvXW,
                                                fpuCvtW, fpuCvtWu};
                        c.regWrite = toInt;
                        c.fpRegWrite = !toInt;
                        c.wbSrc = toInt ? wbFpu : wbPc;
                end
                default: e.invalid = 1'b1; // not an RV32IF opcode
        endcase
        e.ctrl = c;
        e.imm = refImm(w);
        e.fields = f;
        return e;
endfunction

`endif

//--- sim/decodeStageTb.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStageTb;
        import rvIsaPkg::*;
        import ctrlPkg::*;

        `include "decodeRefModel.svh"

        localparam int numCycles = 3000;
        localparam int waitLimit = 1000;

        logic         clk;
        logic         rstN;
        logic [31:0]  instr;
        logic         instrValid;
        ctrl_t        ctrl;
        logic [31:0]  imm;
        instrFields_t fields;
        logic         invalidOp;
        logic         outValid;

        expect_t      expQ[$];
        expect_t      cur;       // last decode the register stage should hold
        logic         haveOut;   // fields are known once one decode came out
        logic         validSeen; // strobe taken by the DUT at the last edge
        logic         checkEn;
        logic [6:0]   f7List [13];

        decodeStage decodeStage_inst (
                .clk        (clk),
                .rstN       (rstN),
                .instr      (instr),
                .instrValid (instrValid),
                .ctrl       (ctrl),
                .imm        (imm),
                .fields     (fields),
                .invalidOp  (invalidOp),
                .outValid   (outValid)
        );

        always #20 clk = ~clk;

        always @(posedge clk)
                validSeen <= instrValid;

        task automatic abortRun();
                $display("Finished with errors");
                $fatal(1, "decode check failed");
        endtask

        task automatic checkCtrl(input string name, input ctrl_t got, input ctrl_t exp);
                if (got !== exp) begin
                        $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
                        abortRun();
                end
        endtask

        task automatic checkImm(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
                if (got !== exp) begin
                        $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
                        abortRun();
                end
        endtask

        task automatic checkFields(input string name, input instrFields_t got,
                                   input instrFields_t exp);
                if (got !== exp) begin
                        $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
                        abortRun();
                end
        endtask

        task automatic checkBit(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        $display("error at %0t ns: %s expected %b got %b", $time, name, exp, got);
                        abortRun();
                end
        endtask

        function automatic logic [31:0] randomInstr();
                instrFields_t f;
                opcode_e      op;
                f = instrFields_t'($urandom);
                if ($urandom_range(7) == 0)
                        return f; // mostly unknown opcodes in a raw word
                op = op.first();
                repeat ($urandom_range(15))
                        op = op.next();
                f.opcode = op;
                if ($urandom_range(3) != 0)
                        f.funct7 = f7List[$urandom_range(12)];
                if ($urandom_range(1) != 0)
                        f.rs2 = 5'($urandom_range(2)); // reach the convert variants
                return f;
        endfunction

        // outputs are stable at the falling edge
        always @(negedge clk) begin
                if (checkEn) begin
                        checkBit("outValid", outValid, validSeen);
                        if (outValid) begin
                                if (expQ.size() == 0) begin
                                        $display("output at %0t ns with no instruction pending",
                                                 $time);
                                        abortRun();
                                end else begin
                                        cur = expQ.pop_front();
                                        haveOut = 1'b1;
                                        checkCtrl("ctrl", ctrl, cur.ctrl);
                                        checkImm("imm", imm, cur.imm);
                                        checkFields("fields", fields, cur.fields);
                                        checkBit("invalidOp", invalidOp, cur.invalid);
                                end
                        end else begin
                                // no strobe at the last edge so the previous decode holds
                                checkCtrl("ctrl", ctrl, cur.ctrl);
                                checkImm("imm", imm, cur.imm);
                                checkBit("invalidOp", invalidOp, cur.invalid);
                                if (haveOut)
                                        checkFields("fields", fields, cur.fields);
                        end
                end
        end

        initial begin
                int          waited;
                logic [31:0] word;
                logic        v;
                clk = 1'b0;
                rstN = 1'b0;
                instr = '0;
                instrValid = 1'b0;
                validSeen = 1'b0;
                checkEn = 1'b0;
                haveOut = 1'b0;
                cur.ctrl = ctrlNop; // reset values until the first decode
                cur.imm = '0;
                cur.fields = '0;
                cur.invalid = 1'b0;
                f7List = '{funct7Base, funct7Alt, funct7FSub, funct7FMul, funct7FDiv,
                           funct7FSqrt, funct7FSgnj, funct7FMinMax, funct7FCmp,
                           funct7FMvXW, funct7FCvtWS, funct7FCvtSW, funct7FMvWX};
                void'($urandom(32'h445d4773));
                repeat (4) @(posedge clk);
                rstN <= 1'b1;
                @(negedge clk);
                checkBit("outValid", outValid, 1'b0); // nothing strobed yet
                checkBit("invalidOp", invalidOp, 1'b0);
                checkCtrl("ctrl", ctrl, ctrlNop);
                checkImm("imm", imm, 32'h0);
                for (int i = 0; i < numCycles; i++) begin
                        @(posedge clk);
                        checkEn = 1'b1;
                        v = ($urandom_range(3) != 0);
                        word = randomInstr();
                        instr <= word;
                        instrValid <= v;
                        if (v)
                                expQ.push_back(refDecode(word));
                end
                @(posedge clk);
                instrValid <= 1'b0;
                waited = 0;
                while (expQ.size() != 0) begin
                        @(posedge clk);
                        waited++;
                        if (waited >= waitLimit) begin
                                $display("timeout: the expected decode output never arrived");
                                abortRun();
                        end
                end
                repeat (3) @(negedge clk); // outValid must stay low when idle
                $display("Finished with no errors");
                $finish;
        end

endmodule

`default_nettype wire

//--- src/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
        input  logic                   clk,
        input  logic                   rstN,
        input  logic [31:0]            instr,
        input  logic                   instrValid,
        output ctrlPkg::ctrl_t         ctrl,
        output logic [31:0]            imm,
        output rvIsaPkg::instrFields_t fields,
        output logic                   invalidOp,
        output logic                   outValid
);
        import rvIsaPkg::*;
        import ctrlPkg::*;

        instrFields_t instrView;
        ctrl_t        decCtrl;
        logic [31:0]  decImm;
        logic         decInvalid;

        assign instrView = instrFields_t'(instr);

        controlUnit controlUnit_inst (
                .instr     (instrView),
                .ctrl      (decCtrl),
                .invalidOp (decInvalid)
        );

        immGen immGen_inst (
                .instr (instrView),
                .imm   (decImm)
        );

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        outValid  <= 1'b0;
                        invalidOp <= 1'b0;
                        ctrl      <= ctrlNop;
                        imm       <= '0;
                end else begin
                        outValid <= instrValid; // one cycle pulse per strobe
                        if (instrValid) begin
                                invalidOp <= decInvalid;
                                ctrl      <= decCtrl;
                                imm       <= decImm;
                        end
                end
        end

        // register indices only
        always_ff @(posedge clk) begin
                if (instrValid)
                        fields <= instrView;
        end

        noValidAfterReset: assert property (@(posedge clk) !rstN |=> !outValid)
                else $error("decodeStage: outValid high right after reset");

endmodule

`default_nettype wire

//--- src/immGen.sv
`timescale 1ns/1ns
`default_nettype none

module immGen (
        input  rvIsaPkg::instrFields_t instr,
        output logic [31:0]            imm
);
        import rvIsaPkg::*;

        logic [31:0] raw;

        assign raw = instr; // immediates cut across field borders

        always_comb begin
                case (instr.opcode)
                        opLoad, opImm, opJalr, opFlw:
                                imm = {{20{raw[31]}}, raw[31:20]};
                        opStore, opFsw:
                                imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};
                        opBranch:
                                imm = {{19{raw[31]}}, raw[31], raw[7], raw[30:25],
                                       raw[11:8], 1'b0};
                        opLui, opAuipc:
                                imm = {raw[31:12], 12'b0};
                        opJal:
                                imm = {{11{raw[31]}}, raw[31], raw[19:12], raw[20],
                                       raw[30:21], 1'b0};
                        default:
                                imm = '0; // R-type and fp ops carry none
                endcase
        end

        // control flow targets are halfword aligned at least
        evenOffset: assert property (@(instr)
                (instr.opcode inside {opBranch, opJal}) |-> !imm[0])
                else $error("immGen: odd branch or jump offset");

endmodule

`default_nettype wire

//--- src/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
        input  rvIsaPkg::instrFields_t instr,
        output ctrlPkg::ctrl_t         ctrl,
        output logic                   invalidOp
);
        import rvIsaPkg::*;
        import ctrlPkg::*;

        // shared by op and imm, only R-type may select sub
        function automatic aluOp_e aluDecode(input logic [2:0] funct3,
                                             input logic [6:0] funct7,
                                             input logic       isReg);
                aluOp_e op;
                case (funct3)
                        3'b000: op = (isReg && funct7 == funct7Alt) ? aluSub : aluAdd;
                        3'b001: op = (funct7 == funct7Base) ? aluSll : aluNone;
                        3'b010: op = aluSlt;
                        3'b011: op = aluSltu;
                        3'b100: op = aluXor;
                        3'b101: begin
                                if (funct7 == funct7Base)
                                        op = aluSrl;
                                else if (funct7 == funct7Alt)
                                        op = aluSra;
                                else
                                        op = aluNone; // bad shift encoding
                        end
                        3'b110: op = aluOr;
                        default: op = aluAnd;
                endcase
                return op;
        endfunction

        function automatic fpuOp_e fpDecode(input logic [6:0] funct7,
                                            input logic [2:0] funct3,
                                            input logic [4:0] rs2);
                fpuOp_e op;
                op = fpuNone;
                case (funct7)
                        funct7FAdd:  op = fpuAdd;
                        funct7FSub:  op = fpuSub;
                        funct7FMul:  op = fpuMul;
                        funct7FDiv:  op = fpuDiv;
                        funct7FSqrt: op = fpuSqrt;
                        funct7FSgnj: begin
                                if (funct3 == 3'b000) op = fpuSgnj;
                                else if (funct3 == 3'b001) op = fpuSgnjn;
                                else if (funct3 == 3'b010) op = fpuSgnjx;
                        end
                        funct7FMinMax: begin
                                if (funct3 == 3'b000) op = fpuMin;
                                else if (funct3 == 3'b001) op = fpuMax;
                        end
                        funct7FCmp: begin
                                if (funct3 == 3'b010) op = fpuEq;
                                else if (funct3 == 3'b001) op = fpuLt;
                                else if (funct3 == 3'b000) op = fpuLe;
                        end
                        funct7FMvXW, funct7FClass: begin // same funct7, funct3 splits
                                if (funct3 == 3'b000) op = fpuMvXW;
                                else if (funct3 == 3'b001) op = fpuClass;
                        end
                        funct7FCvtWS: begin
                                if (rs2 == 5'd0) op = fpuCvtW;
                                else if (rs2 == 5'd1) op = fpuCvtWu;
                        end
                        funct7FCvtSW: begin
                                if (rs2 == 5'd0) op = fpuCvtSW;
                                else if (rs2 == 5'd1) op = fpuCvtSWu;
                        end
                        funct7FMvWX: op = fpuMvWX;
                        default: op = fpuNone;
                endcase
                return op;
        endfunction

        fpuOp_e fpOp;
        logic   fpToInt;

        assign fpOp    = fpDecode(instr.funct7, instr.funct3, instr.rs2);
        assign fpToInt = fpOp inside {fpuEq, fpuLt, fpuLe, fpuClass, fpuMvXW,
                                      fpuCvtW, fpuCvtWu}; // result lands in x regs

        always_comb begin
                ctrl      = ctrlNop;
                invalidOp = 1'b0;
                case (instr.opcode)
                        opOp, opImm: begin
                                ctrl.aluOp    = aluDecode(instr.funct3, instr.funct7,
                                                          instr.opcode == opOp);
                                ctrl.aluSrc   = (instr.opcode == opImm);
                                ctrl.regWrite = 1'b1;
                                ctrl.wbSrc    = wbAlu;
                        end
                        opLoad: begin
                                ctrl.aluOp    = aluAdd; // rs1 + offset
                                ctrl.aluSrc   = 1'b1;
                                ctrl.memRead  = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.wbSrc    = wbMem;
                                case (instr.funct3)
                                        3'b000: ctrl.memOp = memLb;
                                        3'b001: ctrl.memOp = memLh;
                                        3'b010: ctrl.memOp = memLw;
                                        3'b100: ctrl.memOp = memLbu;
                                        3'b101: ctrl.memOp = memLhu;
                                        default: ctrl.memOp = memNone;
                                endcase
                        end
                        opStore: begin
                                ctrl.aluOp    = aluAdd;
                                ctrl.aluSrc   = 1'b1;
                                ctrl.memWrite = 1'b1;
                                case (instr.funct3)
                                        3'b000: ctrl.memOp = memSb;
                                        3'b001: ctrl.memOp = memSh;
                                        3'b010: ctrl.memOp = memSw;
                                        default: ctrl.memOp = memNone;
                                endcase
                        end
                        opBranch: begin
                                ctrl.aluOp  = aluSub; // compare rs1 against rs2
                                ctrl.branch = 1'b1;
                        end
                        opLui: begin
                                ctrl.regWrite = 1'b1;
                                ctrl.wbSrc    = wbImm;
                        end
                        opAuipc: begin
                                ctrl.aluOp    = aluAdd; // pc + upper imm
                                ctrl.aluSrc   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.wbSrc    = wbAlu;
                        end
                        opJal, opJalr: begin
                                if (instr.opcode == opJalr) begin
                                        ctrl.aluOp  = aluAdd; // target from rs1 + imm
                                        ctrl.aluSrc = 1'b1;
                                end
                                ctrl.jump     = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.wbSrc    = wbPc; // link address
                        end
                        opFlw: begin
                                ctrl.aluOp      = aluAdd;
                                ctrl.aluSrc     = 1'b1;
                                ctrl.memRead    = 1'b1;
                                ctrl.memOp      = memLw;
                                ctrl.fpuOp      = fpuLoad;
                                ctrl.fpRegWrite = 1'b1;
                                ctrl.wbSrc      = wbMem;
                        end
                        opFsw: begin
                                ctrl.aluOp    = aluAdd;
                                ctrl.aluSrc   = 1'b1;
                                ctrl.memWrite = 1'b1;
                                ctrl.memOp    = memSw;
                                ctrl.memSrc   = 1'b1;
                                ctrl.fpuOp    = fpuStore;
                        end
                        opFmadd, opFmsub, opFnmsub, opFnmadd: begin
                                case (instr.opcode)
                                        opFmadd: ctrl.fpuOp = fpuMadd;
                                        opFmsub: ctrl.fpuOp = fpuMsub;
                                        opFnmsub: ctrl.fpuOp = fpuNmsub;
                                        default: ctrl.fpuOp = fpuNmadd;
                                endcase
                                ctrl.fpuSrc     = 1'b1; // rs3 operand in use
                                ctrl.fpRegWrite = 1'b1;
                        end
                        opFp: begin
                                ctrl.fpuOp      = fpOp;
                                ctrl.regWrite   = fpToInt;
                                ctrl.fpRegWrite = !fpToInt;
                                if (fpToInt)
                                        ctrl.wbSrc = wbFpu;
                        end
                        default: invalidOp = 1'b1;
                endcase
        end

        // each settled bundle is checked when the next word arrives
        oneWritePort: assert property (@(instr) !(ctrl.regWrite && ctrl.fpRegWrite))
                else $error("controlUnit: int and fp register writes both enabled");

        oneMemAccess: assert property (@(instr) !(ctrl.memRead && ctrl.memWrite))
                else $error("controlUnit: memory read and write both enabled");

endmodule

`default_nettype wire

//--- src/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

        typedef enum logic [3:0] {
                aluAdd,
                aluAnd,
                aluOr,
                aluSll,
                aluSlt,
                aluSltu,
                aluSra,
                aluSrl,
                aluSub,
                aluXor,
                aluNone
        } aluOp_e;

        // order follows the FPU's own op numbering
        typedef enum logic [4:0] {
                fpuNone, fpuLoad, fpuStore,
                fpuMadd, fpuMsub, fpuNmsub, fpuNmadd,
                fpuAdd, fpuSub, fpuMul, fpuDiv, fpuSqrt,
                fpuSgnj, fpuSgnjn, fpuSgnjx,
                fpuMin, fpuMax,
                fpuEq, fpuLt, fpuLe,
                fpuMvXW,
                fpuCvtW, fpuCvtWu, fpuCvtSW, fpuCvtSWu,
                fpuClass,
                fpuMvWX
        } fpuOp_e;

        typedef enum logic [3:0] {
                memNone,
                memLb, memLh, memLw, memLbu, memLhu,
                memSb, memSh, memSw
        } memOp_e;

        // write-back mux select
        typedef enum logic [2:0] {
                wbPc,
                wbMem,
                wbAlu,
                wbFpu,
                wbImm
        } wbSrc_e;

        typedef struct packed {
                aluOp_e aluOp;
                logic   aluSrc;     // operand b is the immediate
                fpuOp_e fpuOp;
                logic   fpuSrc;     // three operand form
                logic   regWrite;
                logic   fpRegWrite;
                logic   branch;
                logic   jump;
                logic   memRead;
                logic   memWrite;
                memOp_e memOp;
                logic   memSrc;     // store data from fp regfile
                wbSrc_e wbSrc;
        } ctrl_t;

        localparam ctrl_t ctrlNop = '{
                aluOp: aluNone, aluSrc: 1'b0,
                fpuOp: fpuNone, fpuSrc: 1'b0,
                regWrite: 1'b0, fpRegWrite: 1'b0,
                branch: 1'b0, jump: 1'b0,
                memRead: 1'b0, memWrite: 1'b0, memOp: memNone, memSrc: 1'b0,
                wbSrc: wbPc
        };

endpackage

`default_nettype wire

//--- src/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

        // major opcodes of RV32I plus the single precision F extension
        typedef enum logic [6:0] {
                opLoad   = 7'b0000011,
                opFlw    = 7'b0000111,
                opImm    = 7'b0010011,
                opAuipc  = 7'b0010111,
                opStore  = 7'b0100011,
                opFsw    = 7'b0100111,
                opOp     = 7'b0110011,
                opLui    = 7'b0110111,
                opFmadd  = 7'b1000011,
                opFmsub  = 7'b1000111,
                opFnmsub = 7'b1001011,
                opFnmadd = 7'b1001111,
                opFp     = 7'b1010011,
                opBranch = 7'b1100011,
                opJalr   = 7'b1100111,
                opJal    = 7'b1101111
        } opcode_e;

        // R-type layout, rs3 sits in funct7[6:2] for the fused ops
        typedef struct packed {
                logic [6:0] funct7;
                logic [4:0] rs2;
                logic [4:0] rs1;
                logic [2:0] funct3;
                logic [4:0] rd;
                opcode_e    opcode;
        } instrFields_t;

        // integer funct7
        localparam logic [6:0] funct7Base    = 7'b0000000;
        localparam logic [6:0] funct7Alt     = 7'b0100000; // sub, sra

        // fp funct7, format bits fixed to single
        localparam logic [6:0] funct7FAdd    = 7'b0000000;
        localparam logic [6:0] funct7FSub    = 7'b0000100;
        localparam logic [6:0] funct7FMul    = 7'b0001000;
        localparam logic [6:0] funct7FDiv    = 7'b0001100;
        localparam logic [6:0] funct7FSqrt   = 7'b0101100;
        localparam logic [6:0] funct7FSgnj   = 7'b0010000;
        localparam logic [6:0] funct7FMinMax = 7'b0010100;
        localparam logic [6:0] funct7FCmp    = 7'b1010000;
        localparam logic [6:0] funct7FMvXW   = 7'b1110000; // funct3 000
        localparam logic [6:0] funct7FClass  = 7'b1110000; // funct3 001
        localparam logic [6:0] funct7FCvtWS  = 7'b1100000; // to integer
        localparam logic [6:0] funct7FCvtSW  = 7'b1101000; // from integer
        localparam logic [6:0] funct7FMvWX   = 7'b1111000;

endpackage

`default_nettype wire
